/* tb.f */
+incdir+.
snake_pkg.sv
snakeBody.sv
blockRasterizer.sv
pixelFifo.sv
frameWriter.sv
snakeGame.sv
snakeGame_asserts.sv
tbClock.sv
snakeGame_tb.sv

/* run.sh */
#!/bin/sh
# build and run the snake game testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module snakeGame_tb -f tb.f -o simv
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit 1
fi

output=$(./obj_dir/simv)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$output" | grep -qx "Everything OK"; then
    exit 0
fi
exit 1

/* snakeGame_tb.sv */
// snake game testbench with a reference snake model and step and direction stimulus
// compares every write with the model and reports one line per test
`timescale 1ns/1ns
`default_nettype none
`include "snake_config.svh"

module snakeGame_tb
    import snake_pkg::*;
();

    localparam int FrameWrites  = (`SNAKE_LEN + 1) * `SEG_DIM * `SEG_DIM;
    localparam int FrameTimeout = 20 * FrameWrites;
    localparam int EventTimeout = 200;

    logic        Clock;
    logic        reset;
    logic        restart;
    logic        dirValid;
    direction_t  dir;
    logic        stepTick;
    logic        writeReady;
    logic        writeValid;
    frameAddr_t  writeAddr;
    logic [2:0]  writeColour;
    logic        gameOver;

    // reference snake with the head at index 0
    int          segX [`SNAKE_LEN];
    int          segY [`SNAKE_LEN];
    direction_t  modelDir;

    // expected writes of the frame in flight
    frameAddr_t  expAddrQ [$];
    logic [2:0]  expColourQ [$];
    frameAddr_t  expAddr;
    logic [2:0]  expColour;

    integer      seed = 8;
    bit          stallOn;
    bit          over;
    int          errors;
    int          checks;
    int          testNum;
    int          errorsAtStart;
    int          stepGuard;

    tbClock clockGen (
        .restart (restart),
        .Clock   (Clock),
        .reset   (reset)
    );

    snakeGame dut (
        .Clock       (Clock),
        .reset       (reset),
        .dirValid    (dirValid),
        .dir         (dir),
        .stepTick    (stepTick),
        .writeReady  (writeReady),
        .writeValid  (writeValid),
        .writeAddr   (writeAddr),
        .writeColour (writeColour),
        .gameOver    (gameOver)
    );

    // frame buffer stalls about one cycle in four once enabled
    always @(posedge Clock)
    begin
        if (stallOn)
            writeReady <= ($random(seed) & 3) != 0;
        else
            writeReady <= 1'b1;
    end

    // every accepted write against the head of the expected queue
    always @(posedge Clock)
    begin
        if (!reset && writeValid && writeReady)
        begin
            if (expAddrQ.size() == 0)
            begin
                errors++;
                $display("unexpected write to address %h while no frame was pending",
                         writeAddr);
            end
            else
            begin
                expAddr   = expAddrQ.pop_front();
                expColour = expColourQ.pop_front();
                checks++;
                assert (writeAddr == expAddr)
                else
                begin
                    errors++;
                    $display("ERR writeAddr got %h expected %h", writeAddr, expAddr);
                end
                assert (writeColour == expColour)
                else
                begin
                    errors++;
                    $display("ERR writeColour got %h expected %h", writeColour, expColour);
                end
            end
        end
    end

    function automatic int totalErrors();
        return errors + dut.checks.failCount;
    endfunction

    // start column with the head on top
    task automatic resetModel();
        for (int k = 0; k < `SNAKE_LEN; k++)
        begin
            segX[k] = `START_X;
            segY[k] = `START_Y + k * `SEG_DIM;
        end
        modelDir = dirUp;
    endtask

    // one game step that returns 1 when the move ends the game
    function automatic bit modelStep();
        int nx;
        int ny;
        bit ended;
        nx    = segX[0];
        ny    = segY[0];
        ended = 1'b0;
        case (modelDir)
            dirUp:   ny = ny - `SEG_DIM;
            dirDown: ny = ny + `SEG_DIM;
            dirLeft: nx = nx - `SEG_DIM;
            default: nx = nx + `SEG_DIM;
        endcase
        if (nx < 0 || ny < 0 || nx > `SCREEN_W - `SEG_DIM || ny > `SCREEN_H - `SEG_DIM)
            ended = 1'b1;
        // tail leaves its block, so only the others count
        for (int k = 0; k < `SNAKE_LEN - 1; k++)
        begin
            if (segX[k] == nx && segY[k] == ny)
                ended = 1'b1;
        end
        if (!ended)
        begin
            for (int k = `SNAKE_LEN - 1; k > 0; k--)
            begin
                segX[k] = segX[k-1];
                segY[k] = segY[k-1];
            end
            segX[0] = nx;
            segY[0] = ny;
        end
        return ended;
    endfunction

    // row-major pixels of one block
    task automatic queueBlock(input int x, input int y, input int colour);
        for (int r = 0; r < `SEG_DIM; r++)
        begin
            for (int c = 0; c < `SEG_DIM; c++)
            begin
                expAddrQ.push_back(frameAddr_t'((y + r) * `SCREEN_W + x + c));
                expColourQ.push_back(3'(colour));
            end
        end
    endtask

    // apple first, then head to tail
    task automatic queueFrame();
        queueBlock(`APPLE_X, `APPLE_Y, `APPLE_COLOUR);
        for (int k = 0; k < `SNAKE_LEN; k++)
            queueBlock(segX[k], segY[k], `SNAKE_COLOUR);
    endtask

    task automatic pulseStep();
        @(posedge Clock);
        stepTick <= 1'b1;
        @(posedge Clock);
        stepTick <= 1'b0;
    endtask

    task automatic setDir(input direction_t newDir);
        @(posedge Clock);
        dirValid <= 1'b1;
        dir      <= newDir;
        @(posedge Clock);
        dirValid <= 1'b0;
        modelDir = newDir;
    endtask

    task automatic waitReset();
        int cycles;
        cycles = 0;
        while (reset && cycles < EventTimeout)
        begin
            @(posedge Clock);
            cycles++;
        end
        if (reset)
        begin
            errors++;
            $display("timeout: reset was never released");
        end
    endtask

    // all expected writes seen
    task automatic waitFrame();
        int cycles;
        cycles = 0;
        while (expAddrQ.size() != 0 && cycles < FrameTimeout)
        begin
            @(posedge Clock);
            cycles++;
        end
        if (expAddrQ.size() != 0)
        begin
            errors++;
            $display("timeout: frame still missed %0d of %0d writes after %0d cycles",
                     expAddrQ.size(), FrameWrites, cycles);
            expAddrQ.delete();
            expColourQ.delete();
        end
    endtask

    task automatic waitGameOver();
        int cycles;
        cycles = 0;
        while (!gameOver && cycles < EventTimeout)
        begin
            @(posedge Clock);
            cycles++;
        end
        if (!gameOver)
        begin
            errors++;
            $display("timeout: gameOver did not rise after a losing step");
        end
    endtask

    // model step, then the DUT step, then its frame or its game over
    task automatic runStep(output bit ended);
        ended = modelStep();
        if (!ended)
            queueFrame();
        pulseStep();
        if (ended)
            waitGameOver();
        else
            waitFrame();
        assert (gameOver == ended)
        else
        begin
            errors++;
            $display("ERR gameOver got %h expected %h", gameOver, ended);
        end
    endtask

    task automatic finishTest(input string name);
        if (totalErrors() == errorsAtStart)
            $display("test %0d %s: pass", testNum, name);
        else
            $display("test %0d %s: FAIL, %0d errors", testNum, name,
                     totalErrors() - errorsAtStart);
        errorsAtStart = totalErrors();
        testNum++;
    endtask

    initial
    begin
        restart       = 1'b0;
        dirValid      = 1'b0;
        dir           = dirUp;
        stepTick      = 1'b0;
        writeReady    = 1'b1;
        stallOn       = 1'b0;
        errors        = 0;
        checks        = 0;
        testNum       = 1;
        errorsAtStart = 0;
        resetModel();
        @(posedge Clock);
        waitReset();

        // idle window watched by the bound checks
        repeat (20) @(posedge Clock);
        assert (!writeValid && !gameOver)
        else
        begin
            errors++;
            $display("ERR writeValid %h gameOver %h expected 0 before any step",
                     writeValid, gameOver);
        end
        finishTest("idle after reset");

        runStep(over);
        finishTest("single step up");

        stallOn <= 1'b1;
        runStep(over);
        finishTest("step under back-pressure");

        setDir(dirLeft);
        runStep(over);
        finishTest("turn left");

        // walk into the left wall
        over      = 1'b0;
        stepGuard = 0;
        while (!over && stepGuard < 20)
        begin
            runStep(over);
            stepGuard++;
        end
        if (!over)
        begin
            errors++;
            $display("snake never reached the left edge within %0d steps", stepGuard);
        end
        // later ticks must draw nothing
        pulseStep();
        pulseStep();
        repeat (100) @(posedge Clock);
        assert (gameOver && !writeValid)
        else
        begin
            errors++;
            $display("ERR gameOver %h writeValid %h expected 1 and 0 after the wall",
                     gameOver, writeValid);
        end
        finishTest("left wall ends game");

        // fresh game that turns back into the body
        stallOn <= 1'b0;
        @(posedge Clock);
        restart <= 1'b1;
        @(posedge Clock);
        restart <= 1'b0;
        @(posedge Clock);
        waitReset();
        resetModel();
        setDir(dirUp);
        runStep(over);
        setDir(dirLeft);
        runStep(over);
        setDir(dirDown);
        runStep(over);
        setDir(dirRight);
        runStep(over);
        // no frame may follow the losing step
        repeat (100) @(posedge Clock);
        assert (gameOver && !writeValid)
        else
        begin
            errors++;
            $display("ERR gameOver %h writeValid %h expected 1 and 0 after the fourth step",
                     gameOver, writeValid);
        end
        finishTest("self collision");

        $display("%0d tests, %0d writes checked, %0d errors", testNum - 1, checks,
                 totalErrors());
        if (totalErrors() == 0)
            $display("Everything OK");
        else
            $display("Something failed");
        $finish;
    end

endmodule

`default_nettype wire

/* tbClock.sv */
// testbench clock, 40 ns period
// reset held for 10 cycles at start and again on each restart request
`timescale 1ns/1ns
`default_nettype none

module tbClock
(
    input  wire   restart,
    output logic  Clock,
    output logic  reset
);

    // cycles of reset still to go
    int holdCycles;

    initial
    begin
        Clock      = 1'b0;
        reset      = 1'b1;
        holdCycles = 10;
    end

    always #20 Clock = ~Clock;

    always @(posedge Clock)
    begin
        if (restart)
        begin
            holdCycles <= 10;
            reset      <= 1'b1;
        end
        else if (holdCycles > 1)
            holdCycles <= holdCycles - 1;
        else
        begin
            holdCycles <= 0;
            reset      <= 1'b0;
        end
    end

endmodule

`default_nettype wire

/* snakeGame_asserts.sv */
// bound checks on the snake game outputs and the rasterizer link
// idle before the first step, reset values, valid/ready hold, no write after game over
`timescale 1ns/1ns
`default_nettype none

module snakeGame_asserts
    import snake_pkg::*;
(
    input wire              Clock,
    input wire              reset,
    input wire              stepTick,
    input wire              writeValid,
    input wire              writeReady,
    input wire frameAddr_t  writeAddr,
    input wire [2:0]        writeColour,
    input wire              gameOver,
    input wire              rastValid,
    input wire              rastReady,
    input wire pixelCmd_t   rastCmd
);

    // assertion failures since time zero
    int   failCount;
    logic stepSeen;

    initial failCount = 0;

    // first step request since the last reset
    always @(posedge Clock)
    begin
        if (reset)
            stepSeen <= 1'b0;
        else if (stepTick)
            stepSeen <= 1'b1;
    end

    // no write and no game over until a step is requested
    idleBeforeStep: assert property (@(posedge Clock) disable iff (reset)
        !stepSeen |-> !writeValid && !gameOver)
        else
        begin
            failCount++;
            $error("write port or gameOver active before any step");
        end

    resetValues: assert property (@(posedge Clock)
        reset |=> !writeValid && !gameOver)
        else
        begin
            failCount++;
            $error("writeValid or gameOver high after reset");
        end

    // stalled write keeps its address and colour
    writeHold: assert property (@(posedge Clock) disable iff (reset)
        writeValid && !writeReady |=> writeValid && $stable(writeAddr)
            && $stable(writeColour))
        else
        begin
            failCount++;
            $error("write port changed while stalled");
        end

    // rasterizer command held until the FIFO takes it
    rastHold: assert property (@(posedge Clock) disable iff (reset)
        rastValid && !rastReady |=> rastValid && $stable(rastCmd))
        else
        begin
            failCount++;
            $error("rasterizer command changed while stalled");
        end

    // once the game is over and the port has drained nothing new is drawn
    noWriteAfterOver: assert property (@(posedge Clock) disable iff (reset)
        gameOver && !writeValid |=> !writeValid)
        else
        begin
            failCount++;
            $error("write issued after game over");
        end

endmodule

bind snakeGame snakeGame_asserts checks (
    .Clock       (Clock),
    .reset       (reset),
    .stepTick    (stepTick),
    .writeValid  (writeValid),
    .writeReady  (writeReady),
    .writeAddr   (writeAddr),
    .writeColour (writeColour),
    .gameOver    (gameOver),
    .rastValid   (rastValid),
    .rastReady   (rastReady),
    .rastCmd     (rastCmd)
);

`default_nettype wire

/* snakeGame.sv */
// snake game top: snake state and rasterizer, pixel FIFO, frame-buffer writer
`timescale 1ns/1ns
`default_nettype none
`include "snake_config.svh"

module snakeGame
    import snake_pkg::*;
(
    input  wire             Clock,
    input  wire             reset,
    input  wire             dirValid,
    input  wire direction_t dir,
    input  wire             stepTick,
    input  wire             writeReady,
    output logic            writeValid,
    output frameAddr_t      writeAddr,
    output logic [2:0]      writeColour,
    output logic            gameOver
);

    // body to rasterizer
    logic                        moved;
    logic                        busy;
    position_t [`SNAKE_LEN-1:0]  segments;

    // rasterizer to FIFO
    logic       rastValid;
    logic       rastReady;
    pixelCmd_t  rastCmd;

    // FIFO to writer
    logic       fifoValid;
    logic       fifoReady;
    pixelCmd_t  fifoCmd;

    snakeBody body (
        .Clock    (Clock),
        .reset    (reset),
        .dirValid (dirValid),
        .dir      (dir),
        .stepTick (stepTick),
        .busy     (busy),
        .moved    (moved),
        .segments (segments),
        .gameOver (gameOver)
    );

    blockRasterizer raster (
        .Clock    (Clock),
        .reset    (reset),
        .moved    (moved),
        .segments (segments),
        .cmdReady (rastReady),
        .busy     (busy),
        .cmdValid (rastValid),
        .cmd      (rastCmd)
    );

    pixelFifo #(
        .Depth (`FIFO_DEPTH)
    ) fifo (
        .Clock    (Clock),
        .reset    (reset),
        .inValid  (rastValid),
        .inCmd    (rastCmd),
        .outReady (fifoReady),
        .inReady  (rastReady),
        .outValid (fifoValid),
        .outCmd   (fifoCmd)
    );

    frameWriter writer (
        .Clock       (Clock),
        .reset       (reset),
        .cmdValid    (fifoValid),
        .cmd         (fifoCmd),
        .writeReady  (writeReady),
        .cmdReady    (fifoReady),
        .writeValid  (writeValid),
        .writeAddr   (writeAddr),
        .writeColour (writeColour)
    );

endmodule

`default_nettype wire

/* frameWriter.sv */
// one-entry frame-buffer writer stage
// converts pixel position to linear address y * width + x
`timescale 1ns/1ns
`default_nettype none
`include "snake_config.svh"

module frameWriter
    import snake_pkg::*;
(
    input  wire             Clock,
    input  wire             reset,
    input  wire             cmdValid,
    input  wire pixelCmd_t  cmd,
    input  wire             writeReady,
    output logic            cmdReady,
    output logic            writeValid,
    output frameAddr_t      writeAddr,
    output logic [2:0]      writeColour
);

    // ready when empty or when the held write leaves this cycle
    assign cmdReady = !writeValid || writeReady;

    // address computed once as the command is loaded
    always_ff @(posedge Clock)
    begin
        if (cmdValid && cmdReady)
        begin
            writeAddr   <= frameAddr_t'(cmd.position.y) * frameAddr_t'(`SCREEN_W)
                           + frameAddr_t'(cmd.position.x);
            writeColour <= cmd.colour;
        end
    end

    always_ff @(posedge Clock)
    begin
        if (reset)
            writeValid <= 1'b0;
        else if (cmdValid && cmdReady)
            writeValid <= 1'b1;
        else if (writeReady)
            writeValid <= 1'b0;
    end

endmodule

`default_nettype wire

/* pixelFifo.sv */
// pixel command FIFO, circular buffer with valid/ready on both sides
`timescale 1ns/1ns
`default_nettype none
`include "snake_config.svh"

module pixelFifo
    import snake_pkg::*;
#(
    parameter int Depth = `FIFO_DEPTH
)
(
    input  wire             Clock,
    input  wire             reset,
    input  wire             inValid,
    input  wire pixelCmd_t  inCmd,
    input  wire             outReady,
    output logic            inReady,
    output logic            outValid,
    output pixelCmd_t       outCmd
);

    localparam int PtrW   = $clog2(Depth);
    localparam int CountW = $clog2(Depth + 1);

    pixelCmd_t          mem [Depth];
    logic [PtrW-1:0]    wrPtr;
    logic [PtrW-1:0]    rdPtr;
    logic [CountW-1:0]  count;
    logic               push;
    logic               pop;

    assign inReady  = count != CountW'(Depth);
    assign outValid = count != '0;
    assign outCmd   = mem[rdPtr];
    assign push     = inValid && inReady;
    assign pop      = outValid && outReady;

    always_ff @(posedge Clock)
    begin
        if (push)
            mem[wrPtr] <= inCmd;
    end

    always_ff @(posedge Clock)
    begin
        if (reset)
        begin
            wrPtr <= '0;
            rdPtr <= '0;
            count <= '0;
        end
        else
        begin
            // pointers wrap at Depth, which need not be a power of two
            if (push)
                wrPtr <= (wrPtr == PtrW'(Depth - 1)) ? '0 : wrPtr + 1'b1;
            if (pop)
                rdPtr <= (rdPtr == PtrW'(Depth - 1)) ? '0 : rdPtr + 1'b1;
            // simultaneous push and pop leaves count alone
            if (push && !pop)
                count <= count + 1'b1;
            else if (pop && !push)
                count <= count - 1'b1;
        end
    end

endmodule

`default_nettype wire

/* blockRasterizer.sv */
// block rasterizer: apple block then every snake block, head to tail
// one pixel command per pixel, row-major, valid/ready output
`timescale 1ns/1ns
`default_nettype none
`include "snake_config.svh"

module blockRasterizer
    import snake_pkg::*;
(
    input  wire                          Clock,
    input  wire                          reset,
    input  wire                          moved,
    input  wire position_t [`SNAKE_LEN-1:0] segments,
    input  wire                          cmdReady,
    output logic                         busy,
    output logic                         cmdValid,
    output pixelCmd_t                    cmd
);

    localparam int BlockW = $clog2(`SNAKE_LEN + 1);
    localparam int CountW = $clog2(`SEG_DIM);

    // block 0 is the apple, block k is segment k-1
    logic [BlockW-1:0]             blockIdx;
    logic [CountW-1:0]             row;
    logic [CountW-1:0]             col;
    position_t [`SNAKE_LEN-1:0]    segLatch;
    position_t                     base;
    logic                          accept;
    logic                          lastCol;
    logic                          lastRow;
    logic                          lastBlock;

    assign cmdValid  = busy;
    assign accept    = cmdValid && cmdReady;
    assign lastCol   = col == CountW'(`SEG_DIM - 1);
    assign lastRow   = row == CountW'(`SEG_DIM - 1);
    assign lastBlock = blockIdx == BlockW'(`SNAKE_LEN);

    // counters only move on a transfer, so cmd holds while stalled
    always_comb
    begin
        if (blockIdx == '0)
        begin
            base.x     = xCoord_t'(`APPLE_X);
            base.y     = yCoord_t'(`APPLE_Y);
            cmd.colour = 3'(`APPLE_COLOUR);
        end
        else
        begin
            base       = segLatch[blockIdx - 1'b1];
            cmd.colour = 3'(`SNAKE_COLOUR);
        end
        cmd.position.x = base.x + xCoord_t'(col);
        cmd.position.y = base.y + yCoord_t'(row);
    end

    // snapshot of the body for the whole frame
    always_ff @(posedge Clock)
    begin
        if (moved)
            segLatch <= segments;
    end

    always_ff @(posedge Clock)
    begin
        if (reset)
        begin
            busy     <= 1'b0;
            blockIdx <= '0;
            row      <= '0;
            col      <= '0;
        end
        else if (moved)
        begin
            // new frame starts with the apple
            busy     <= 1'b1;
            blockIdx <= '0;
            row      <= '0;
            col      <= '0;
        end
        else if (accept)
        begin
            col <= lastCol ? '0 : col + 1'b1;
            if (lastCol)
            begin
                row <= lastRow ? '0 : row + 1'b1;
                if (lastRow)
                begin
                    blockIdx <= blockIdx + 1'b1;
                    // tail block done
                    if (lastBlock)
                        busy <= 1'b0;
                end
            end
        end
    end

endmodule

`default_nettype wire

/* snakeBody.sv */
// snake state: held direction, segment positions, body shift
// head movement with wall and self collision, game-over latch
`timescale 1ns/1ns
`default_nettype none
`include "snake_config.svh"

module snakeBody
    import snake_pkg::*;
(
    input  wire                          Clock,
    input  wire                          reset,
    input  wire                          dirValid,
    input  wire direction_t              dir,
    input  wire                          stepTick,
    input  wire                          busy,
    output logic                         moved,
    output position_t [`SNAKE_LEN-1:0]   segments,
    output logic                         gameOver
);

    direction_t headDir;
    position_t  nextHead;
    logic       offScreen;
    logic       bodyHit;
    logic       stepAccept;

    // step also refused in the moved cycle, the rasterizer has not raised busy yet
    assign stepAccept = stepTick && !busy && !moved && !gameOver;

    // candidate head one block away from the current head
    always_comb
    begin
        nextHead  = segments[0];
        offScreen = 1'b0;
        case (headDir)
            dirUp:
            begin
                offScreen  = int'(segments[0].y) < `SEG_DIM;
                nextHead.y = segments[0].y - yCoord_t'(`SEG_DIM);
            end
            dirDown:
            begin
                offScreen  = int'(segments[0].y) + `SEG_DIM > `SCREEN_H - `SEG_DIM;
                nextHead.y = segments[0].y + yCoord_t'(`SEG_DIM);
            end
            dirLeft:
            begin
                offScreen  = int'(segments[0].x) < `SEG_DIM;
                nextHead.x = segments[0].x - xCoord_t'(`SEG_DIM);
            end
            default:
            begin
                offScreen  = int'(segments[0].x) + `SEG_DIM > `SCREEN_W - `SEG_DIM;
                nextHead.x = segments[0].x + xCoord_t'(`SEG_DIM);
            end
        endcase
    end

    // tail block moves away this step, so it is left out
    always_comb
    begin
        bodyHit = 1'b0;
        for (int k = 0; k < `SNAKE_LEN - 1; k++)
        begin
            if (segments[k] == nextHead)
                bodyHit = 1'b1;
        end
    end

    always_ff @(posedge Clock)
    begin
        if (reset)
        begin
            headDir  <= dirUp;
            moved    <= 1'b0;
            gameOver <= 1'b0;
            // vertical column below the head
            for (int k = 0; k < `SNAKE_LEN; k++)
            begin
                segments[k].x <= xCoord_t'(`START_X);
                segments[k].y <= yCoord_t'(`START_Y + k * `SEG_DIM);
            end
        end
        else
        begin
            moved <= 1'b0;
            if (dirValid)
                headDir <= dir;
            if (stepAccept)
            begin
                if (offScreen || bodyHit)
                    gameOver <= 1'b1;
                else
                begin
                    // each segment follows its predecessor
                    segments[0] <= nextHead;
                    for (int k = 1; k < `SNAKE_LEN; k++)
                        segments[k] <= segments[k-1];
                    moved <= 1'b1;
                end
            end
        end
    end

endmodule

`default_nettype wire

/* snake_pkg.sv */
// shared types for the snake engine
// coordinates, positions, directions, pixel commands, frame addresses
`default_nettype none

package snake_pkg;

    // screen coordinates, 160 wide needs 8 bits, 120 high needs 7
    typedef logic [7:0] xCoord_t;
    typedef logic [6:0] yCoord_t;

    // top-left corner of a block or a single pixel
    typedef struct packed {
        xCoord_t x;
        yCoord_t y;
    } position_t;

    // held movement direction
    typedef enum logic [1:0] {
        dirUp,
        dirDown,
        dirLeft,
        dirRight
    } direction_t;

    // one pixel to be written
    typedef struct packed {
        position_t   position;
        logic [2:0]  colour;
    } pixelCmd_t;

    // linear frame-buffer address, y * width + x
    typedef logic [14:0] frameAddr_t;

endpackage

`default_nettype wire

/* snake_config.svh */
// game configuration macros
// screen, block and snake dimensions, start and apple positions, colours, FIFO depth
`ifndef SNAKE_CONFIG_SVH
`define SNAKE_CONFIG_SVH

// frame buffer size in pixels
`define SCREEN_W 160
`define SCREEN_H 120

// edge of one square block
`define SEG_DIM 10

// fixed snake length in blocks
`define SNAKE_LEN 6

// head at reset, body hangs straight down below it
`define START_X 80
`define START_Y 60

// top-left corner of the apple block
`define APPLE_X 30
`define APPLE_Y 30

// 3-bit colours
`define APPLE_COLOUR 4
`define SNAKE_COLOUR 2

// entries in the pixel FIFO
`define FIFO_DEPTH 16

`endif
